//--- src/mmuPkg.sv
`default_nettype none

package mmuPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address and TLB geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int addressWidth = 32;
	localparam int pageOffsetWidth = 12;
	localparam int pageNumberWidth = 20;
	localparam int entryCount = 32;
	localparam int indexWidth = 5;

	// entries 0 to 3 are kept for fixed mappings and never picked by TBWR
	localparam int firstRandomIndex = 4;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// entry types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the page number is the search key of an entry
	typedef logic [pageNumberWidth-1:0] pageNumberT;
	typedef logic [indexWidth-1:0] entryIndexT;

	// value part of an entry, frame number on top and the two flags below
	typedef struct packed {
		pageNumberT frameNumber;
		logic writeAllowed;
		logic valid;
	} entryValueT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register load sources and read codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [0:0] {indexExplicit = 1'b0, indexSearch = 1'b1} indexSourceT;

	typedef enum logic [1:0] {
		highExplicit = 2'd0,
		highVirtualAddress = 2'd1,
		highReadEntry = 2'd2
	} highSourceT;

	typedef enum logic [1:0] {lowExplicit = 2'd0, lowMatchValue = 2'd1, lowReadEntry = 2'd2} lowSourceT;

	typedef enum logic [0:0] {badExplicit = 1'b0, badVirtualAddress = 1'b1} badSourceT;

	// same numbering as the low bits of the MVFS and MVTS instructions
	typedef enum logic [2:0] {
		registerIndex = 3'd1,
		registerEntryHigh = 3'd2,
		registerEntryLow = 3'd3,
		registerBadAddress = 3'd4
	} specialRegisterT;

endpackage

`default_nettype wire

//--- src/tlbPort.sv
`default_nettype none
`timescale 1ns/1ps

// shared TLB access bundle between the entry store, the register file and
// the translation unit
interface tlbPort;
	import mmuPkg::*;

	// associative search, key comes from the translation unit
	pageNumberT searchKey;
	logic found;
	entryIndexT matchIndex;
	entryValueT matchValue;

	// indexed access used by TBRI, TBWI and TBWR
	entryIndexT accessIndex;
	pageNumberT readKey;
	entryValueT readValue;
	pageNumberT writeKey;
	entryValueT writeValue;
	logic writeEnable;

	// current random counter value, for TBWR
	entryIndexT randomIndex;

	modport store (
		input searchKey, accessIndex, writeKey, writeValue, writeEnable,
		output found, matchIndex, matchValue, readKey, readValue
	);

	modport registers (
		input found, matchIndex, matchValue, readKey, readValue, randomIndex,
		output accessIndex, writeKey, writeValue, writeEnable
	);

	modport translator (
		input found, matchValue,
		output searchKey, randomIndex
	);

endinterface

`default_nettype wire

//--- src/tlbEntryStore.sv
`default_nettype none
`timescale 1ns/1ps

module tlbEntryStore (
	input wire logic clock,
	input wire logic reset,
	tlbPort.store tlb
);
	import mmuPkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// key and value memories
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pageNumberT keys [entryCount];
	entryValueT values [entryCount];

	// one compare result per entry
	logic [entryCount-1:0] hits;
	logic anyHit;
	entryIndexT lowestHit;

	// every entry goes back to zero on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < entryCount; i++) begin
				keys[i] <= '0;
				values[i] <= '0;
			end
		end else if (tlb.writeEnable) begin
			// key and value are always written as a pair
			keys[tlb.accessIndex] <= tlb.writeKey;
			values[tlb.accessIndex] <= tlb.writeValue;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// associative search
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < entryCount; i++) begin
			hits[i] = (keys[i] == tlb.searchKey);
		end
	end

	assign anyHit = |hits;

	// walk from the top down so the last assignment is the lowest matching entry.
	// Duplicate keys are legal and the lowest index has priority
	always_comb begin
		lowestHit = '0;
		for (int i = entryCount - 1; i >= 0; i--) begin
			if (hits[i]) begin
				lowestHit = entryIndexT'(i);
			end
		end
	end

	assign tlb.found = anyHit;
	assign tlb.matchIndex = lowestHit;

	// a miss reports an all-zero value instead of whatever entry 0 holds
	assign tlb.matchValue = anyHit ? values[lowestHit] : '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// indexed read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// combinational, so TBRI loads the registers at the same edge
	assign tlb.readKey = keys[tlb.accessIndex];
	assign tlb.readValue = values[tlb.accessIndex];

	// the write index comes from another module and must be settled when it is used
	writeIndexKnown: assert property (
		@(posedge clock) disable iff (reset)
		tlb.writeEnable |-> !$isunknown(tlb.accessIndex)
	);

endmodule

`default_nettype wire

//--- src/tlbRegisterFile.sv
`default_nettype none
`timescale 1ns/1ps

module tlbRegisterFile (
	input wire logic clock,
	input wire logic reset,
	input wire logic [mmuPkg::addressWidth-1:0] virtualAddress,
	input wire logic randomizeEntryIndex,
	input wire logic writeEntryEnable,
	input wire logic [mmuPkg::addressWidth-1:0] specialRegisterExplicitWriteValue,
	input wire logic tlbIndexWriteEnable,
	input wire mmuPkg::indexSourceT tlbIndexDataSource,
	input wire logic tlbEntryHighWriteEnable,
	input wire mmuPkg::highSourceT tlbEntryHighDataSource,
	input wire logic tlbEntryLowWriteEnable,
	input wire mmuPkg::lowSourceT tlbEntryLowDataSource,
	input wire logic tlbBadAddressWriteEnable,
	input wire mmuPkg::badSourceT tlbBadAddressDataSource,
	input wire mmuPkg::specialRegisterT readIndex,
	output logic [mmuPkg::addressWidth-1:0] readValue,
	tlbPort.registers tlb
);
	import mmuPkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program-visible registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// index register and its bit 31, which TBS sets on a miss
	entryIndexT indexRegister;
	logic invalidIndex;

	// entry high holds only the page number, the offset bits always read as zero
	pageNumberT entryHigh;
	entryValueT entryLow;
	logic [addressWidth-1:0] badAddress;

	// index register load
	always_ff @(posedge clock) begin
		if (reset) begin
			indexRegister <= '0;
			invalidIndex <= 1'b0;
		end else if (tlbIndexWriteEnable) begin
			case (tlbIndexDataSource)
				indexExplicit: begin
					// MVTS always leaves the index valid
					indexRegister <= specialRegisterExplicitWriteValue[indexWidth-1:0];
					invalidIndex <= 1'b0;
				end
				indexSearch: begin
					indexRegister <= tlb.found ? tlb.matchIndex : '0;
					invalidIndex <= !tlb.found;
				end
				default: begin
					// unknown source code, keep the old contents
				end
			endcase
		end
	end

	// entry high load
	always_ff @(posedge clock) begin
		if (reset) begin
			entryHigh <= '0;
		end else if (tlbEntryHighWriteEnable) begin
			case (tlbEntryHighDataSource)
				highExplicit: begin
					entryHigh <= specialRegisterExplicitWriteValue[addressWidth-1:pageOffsetWidth];
				end
				highVirtualAddress: begin
					// page number of the faulting or searched address
					entryHigh <= virtualAddress[addressWidth-1:pageOffsetWidth];
				end
				highReadEntry: begin
					entryHigh <= tlb.readKey;
				end
				default: begin
					// code 3 is unused and holds
				end
			endcase
		end
	end

	// entry low load
	always_ff @(posedge clock) begin
		if (reset) begin
			entryLow <= '0;
		end else if (tlbEntryLowWriteEnable) begin
			case (tlbEntryLowDataSource)
				lowExplicit: begin
					// only the frame number and the two flag bits are kept
					entryLow.frameNumber <=
						specialRegisterExplicitWriteValue[addressWidth-1:pageOffsetWidth];
					entryLow.writeAllowed <= specialRegisterExplicitWriteValue[1];
					entryLow.valid <= specialRegisterExplicitWriteValue[0];
				end
				lowMatchValue: begin
					entryLow <= tlb.matchValue;
				end
				lowReadEntry: begin
					entryLow <= tlb.readValue;
				end
				default: begin
					// code 3 is unused and holds
				end
			endcase
		end
	end

	// bad address load
	always_ff @(posedge clock) begin
		if (reset) begin
			badAddress <= '0;
		end else if (tlbBadAddressWriteEnable) begin
			case (tlbBadAddressDataSource)
				badExplicit: begin
					badAddress <= specialRegisterExplicitWriteValue;
				end
				badVirtualAddress: begin
					badAddress <= virtualAddress;
				end
				default: begin
					// unknown source code, keep the old contents
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// entry access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// TBWR takes the counter, TBWI and TBRI take the index register
	assign tlb.accessIndex = randomizeEntryIndex ? tlb.randomIndex : indexRegister;
	assign tlb.writeKey = entryHigh;
	assign tlb.writeValue = entryLow;
	assign tlb.writeEnable = writeEntryEnable;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (readIndex)
			registerIndex: begin
				readValue = {invalidIndex, {(addressWidth - 1 - indexWidth){1'b0}}, indexRegister};
			end
			registerEntryHigh: begin
				readValue = {entryHigh, {pageOffsetWidth{1'b0}}};
			end
			registerEntryLow: begin
				// flags sit in bits 1 and 0, the rest of the offset field reads zero
				readValue = {
					entryLow.frameNumber,
					{(pageOffsetWidth - 2){1'b0}},
					entryLow.writeAllowed,
					entryLow.valid
				};
			end
			registerBadAddress: begin
				readValue = badAddress;
			end
			default: begin
				readValue = '0;
			end
		endcase
	end

	// TBRI reads through the index register, the counter would pick the wrong entry
	readEntryUsesIndex: assert property (
		@(posedge clock) disable iff (reset)
		randomizeEntryIndex |->
			!(tlbEntryHighWriteEnable && tlbEntryHighDataSource == highReadEntry) &&
			!(tlbEntryLowWriteEnable && tlbEntryLowDataSource == lowReadEntry)
	);

endmodule

`default_nettype wire

//--- src/translationUnit.sv
`default_nettype none
`timescale 1ns/1ps

module translationUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic [mmuPkg::addressWidth-1:0] virtualAddress,
	input wire logic affectRandomIndexCounter,
	output logic tlbMiss,
	output logic [mmuPkg::addressWidth-1:0] physicalAddress,
	output logic physicalAddressWriteAllowed,
	output logic physicalAddressValid,
	tlbPort.translator tlb
);
	import mmuPkg::*;

	// set when both top address bits are one, those addresses bypass the TLB
	logic directMapped;
	pageNumberT frameNumber;
	entryIndexT randomIndexCounter;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode and lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign directMapped = &virtualAddress[addressWidth-1 -: 2];
	assign tlb.searchKey = virtualAddress[addressWidth-1:pageOffsetWidth];

	// direct mapping just clears the two top bits of the page number
	assign frameNumber = directMapped ?
		{2'b00, virtualAddress[addressWidth-3:pageOffsetWidth]} :
		tlb.matchValue.frameNumber;

	// all four results are captured together, so the address is needed for one cycle only
	always_ff @(posedge clock) begin
		if (reset) begin
			tlbMiss <= 1'b0;
			physicalAddress <= '0;
			physicalAddressWriteAllowed <= 1'b0;
			physicalAddressValid <= 1'b0;
		end else begin
			tlbMiss <= !directMapped && !tlb.found;
			physicalAddress <= {frameNumber, virtualAddress[pageOffsetWidth-1:0]};
			physicalAddressWriteAllowed <= directMapped || tlb.matchValue.writeAllowed;
			physicalAddressValid <= directMapped || tlb.matchValue.valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random index counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// steps once per mapped translation and skips the reserved low entries on wrap
	always_ff @(posedge clock) begin
		if (reset) begin
			randomIndexCounter <= entryIndexT'(firstRandomIndex);
		end else if (affectRandomIndexCounter && !directMapped) begin
			if (randomIndexCounter == entryIndexT'(entryCount - 1)) begin
				randomIndexCounter <= entryIndexT'(firstRandomIndex);
			end else begin
				randomIndexCounter <= randomIndexCounter + 1'b1;
			end
		end
	end

	assign tlb.randomIndex = randomIndexCounter;

	// TBWR must never land on one of the reserved entries
	counterInRange: assert property (
		@(posedge clock) disable iff (reset)
		randomIndexCounter >= entryIndexT'(firstRandomIndex)
	);

endmodule

`default_nettype wire

//--- src/memoryManagementUnit.sv
`default_nettype none
`timescale 1ns/1ps

module memoryManagementUnit (
	input wire logic clock,
	input wire logic reset,

	// translation
	input wire logic [mmuPkg::addressWidth-1:0] virtualAddress,
	input wire logic affectRandomIndexCounter,
	output logic tlbMiss,
	output logic [mmuPkg::addressWidth-1:0] physicalAddress,
	output logic physicalAddressWriteAllowed,
	output logic physicalAddressValid,

	// TBWI and TBWR
	input wire logic randomizeEntryIndex,
	input wire logic writeEntryEnable,

	// special register access
	input wire mmuPkg::specialRegisterT specialRegisterReadIndex,
	output logic [mmuPkg::addressWidth-1:0] specialRegisterReadValue,
	input wire logic [mmuPkg::addressWidth-1:0] specialRegisterExplicitWriteValue,
	input wire logic tlbIndexWriteEnable,
	input wire mmuPkg::indexSourceT tlbIndexDataSource,
	input wire logic tlbEntryHighWriteEnable,
	input wire mmuPkg::highSourceT tlbEntryHighDataSource,
	input wire logic tlbEntryLowWriteEnable,
	input wire mmuPkg::lowSourceT tlbEntryLowDataSource,
	input wire logic tlbBadAddressWriteEnable,
	input wire mmuPkg::badSourceT tlbBadAddressDataSource
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shared TLB access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	tlbPort tlb ();

	// key and value memories with the associative search
	tlbEntryStore entryStore (
		.clock(clock),
		.reset(reset),
		.tlb(tlb.store)
	);

	// special registers, they also pick the entry index and supply write data
	tlbRegisterFile registerFile (
		.clock(clock),
		.reset(reset),
		.virtualAddress(virtualAddress),
		.randomizeEntryIndex(randomizeEntryIndex),
		.writeEntryEnable(writeEntryEnable),
		.specialRegisterExplicitWriteValue(specialRegisterExplicitWriteValue),
		.tlbIndexWriteEnable(tlbIndexWriteEnable),
		.tlbIndexDataSource(tlbIndexDataSource),
		.tlbEntryHighWriteEnable(tlbEntryHighWriteEnable),
		.tlbEntryHighDataSource(tlbEntryHighDataSource),
		.tlbEntryLowWriteEnable(tlbEntryLowWriteEnable),
		.tlbEntryLowDataSource(tlbEntryLowDataSource),
		.tlbBadAddressWriteEnable(tlbBadAddressWriteEnable),
		.tlbBadAddressDataSource(tlbBadAddressDataSource),
		.readIndex(specialRegisterReadIndex),
		.readValue(specialRegisterReadValue),
		.tlb(tlb.registers)
	);

	// direct-mapping decode, registered results and the TBWR counter
	translationUnit translator (
		.clock(clock),
		.reset(reset),
		.virtualAddress(virtualAddress),
		.affectRandomIndexCounter(affectRandomIndexCounter),
		.tlbMiss(tlbMiss),
		.physicalAddress(physicalAddress),
		.physicalAddressWriteAllowed(physicalAddressWriteAllowed),
		.physicalAddressValid(physicalAddressValid),
		.tlb(tlb.translator)
	);

endmodule

`default_nettype wire

//--- tb/mmuChecker.sv
`default_nettype none
`timescale 1ns/1ps

module mmuChecker (
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] virtualAddress,
	input wire logic affectRandomIndexCounter,
	input wire logic randomizeEntryIndex,
	input wire logic writeEntryEnable,
	input wire logic [2:0] specialRegisterReadIndex,
	input wire logic [31:0] specialRegisterExplicitWriteValue,
	input wire logic tlbIndexWriteEnable,
	input wire logic tlbIndexDataSource,
	input wire logic tlbEntryHighWriteEnable,
	input wire logic [1:0] tlbEntryHighDataSource,
	input wire logic tlbEntryLowWriteEnable,
	input wire logic [1:0] tlbEntryLowDataSource,
	input wire logic tlbBadAddressWriteEnable,
	input wire logic tlbBadAddressDataSource,
	input wire logic tlbMiss,
	input wire logic [31:0] physicalAddress,
	input wire logic physicalAddressWriteAllowed,
	input wire logic physicalAddressValid,
	input wire logic [31:0] specialRegisterReadValue,
	output int translationErrors,
	output int registerErrors,
	output int translationChecks,
	output int registerChecks
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// entry values are {frame number, write allowed, valid}
	logic [19:0] modelKey [32];
	logic [21:0] modelValue [32];
	logic [4:0] modelIndex;
	logic modelInvalid;
	logic [19:0] modelHigh;
	logic [21:0] modelLow;
	logic [31:0] modelBad;
	logic [4:0] modelCounter;

	// translation result expected after the last rising edge
	logic expectReady = 1'b0;
	logic expectMiss;
	logic expectTranslated;
	logic [31:0] expectAddress;
	logic expectWrite;
	logic expectValid;

	int translationErrorCount = 0;
	int registerErrorCount = 0;
	int translationCheckCount = 0;
	int registerCheckCount = 0;

	assign translationErrors = translationErrorCount;
	assign registerErrors = registerErrorCount;
	assign translationChecks = translationCheckCount;
	assign registerChecks = registerCheckCount;

	// read port format as the CPU sees each special register
	function automatic logic [31:0] registerView(input logic [2:0] select);
		case (select)
			3'd1: return {modelInvalid, 26'd0, modelIndex};
			3'd2: return {modelHigh, 12'd0};
			3'd3: return {modelLow[21:2], 10'd0, modelLow[1:0]};
			3'd4: return modelBad;
			default: return 32'd0;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read port check and model update at the rising edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clock) begin : modelUpdate
		logic directMapped;
		logic found;
		logic [4:0] matchIndex;
		logic [21:0] matchValue;
		logic [4:0] accessIndex;
		logic [19:0] readKey;
		logic [21:0] readValue;
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				modelKey[i] = '0;
				modelValue[i] = '0;
			end
			modelIndex = '0;
			modelInvalid = 1'b0;
			modelHigh = '0;
			modelLow = '0;
			modelBad = '0;
			modelCounter = 5'd4;
			// only the miss flag is known after reset
			expectMiss = 1'b0;
			expectTranslated = 1'b0;
			expectReady = 1'b1;
		end else begin
			// the read port still shows the contents from before this edge
			registerCheckCount++;
			if (specialRegisterReadValue !== registerView(specialRegisterReadIndex)) begin
				registerErrorCount++;
				$display("Error at %0t ns: read index %0d gave %h, expected %h", $time,
					specialRegisterReadIndex, specialRegisterReadValue,
					registerView(specialRegisterReadIndex));
			end
			// lowest matching entry wins when keys repeat
			directMapped = (virtualAddress[31:30] == 2'b11);
			found = 1'b0;
			matchIndex = '0;
			matchValue = '0;
			for (int i = 0; i < 32; i++) begin
				if (!found && modelKey[i] == virtualAddress[31:12]) begin
					found = 1'b1;
					matchIndex = 5'(i);
					matchValue = modelValue[i];
				end
			end
			expectMiss = !directMapped && !found;
			expectTranslated = directMapped || found;
			expectAddress = directMapped ?
				{2'b00, virtualAddress[29:12], virtualAddress[11:0]} :
				{matchValue[21:2], virtualAddress[11:0]};
			expectWrite = directMapped || matchValue[1];
			expectValid = directMapped || matchValue[0];
			expectReady = 1'b1;

			// TBWR goes through the counter, everything else through the index register
			accessIndex = randomizeEntryIndex ? modelCounter : modelIndex;
			readKey = modelKey[accessIndex];
			readValue = modelValue[accessIndex];
			// the entry write takes the register contents from before this edge
			if (writeEntryEnable) begin
				modelKey[accessIndex] = modelHigh;
				modelValue[accessIndex] = modelLow;
			end
			if (tlbIndexWriteEnable) begin
				modelIndex = tlbIndexDataSource ? matchIndex : specialRegisterExplicitWriteValue[4:0];
				modelInvalid = tlbIndexDataSource && !found;
			end
			if (tlbEntryHighWriteEnable) begin
				case (tlbEntryHighDataSource)
					2'd0: modelHigh = specialRegisterExplicitWriteValue[31:12];
					2'd1: modelHigh = virtualAddress[31:12];
					2'd2: modelHigh = readKey;
					default: modelHigh = modelHigh;
				endcase
			end
			if (tlbEntryLowWriteEnable) begin
				case (tlbEntryLowDataSource)
					2'd0: modelLow = {specialRegisterExplicitWriteValue[31:12],
						specialRegisterExplicitWriteValue[1:0]};
					2'd1: modelLow = matchValue;
					2'd2: modelLow = readValue;
					default: modelLow = modelLow;
				endcase
			end
			if (tlbBadAddressWriteEnable) begin
				modelBad = tlbBadAddressDataSource ? virtualAddress : specialRegisterExplicitWriteValue;
			end
			// counter runs 4 to 31 and steps only on mapped addresses
			if (affectRandomIndexCounter && !directMapped) begin
				modelCounter = (modelCounter == 5'd31) ? 5'd4 : modelCounter + 5'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered outputs checked at the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clock) begin
		if (expectReady) begin
			translationCheckCount++;
			if (tlbMiss !== expectMiss) begin
				translationErrorCount++;
				$display("Error at %0t ns: tlbMiss is %b, expected %b", $time, tlbMiss, expectMiss);
			end
			// address and flags are only defined on a hit or a direct mapping
			if (expectTranslated && (physicalAddress !== expectAddress ||
					physicalAddressWriteAllowed !== expectWrite ||
					physicalAddressValid !== expectValid)) begin
				translationErrorCount++;
				$display("Error at %0t ns: translation gave %h w%b v%b, expected %h w%b v%b",
					$time, physicalAddress, physicalAddressWriteAllowed, physicalAddressValid,
					expectAddress, expectWrite, expectValid);
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/mmuTestbench.sv
`default_nettype none
`timescale 1ns/1ps

module mmuTestbench;
	import mmuPkg::*;

	localparam int clockPeriod = 20;
	localparam int operationCount = 2000;
	localparam int marginCycles = 100;
	localparam int poolSize = 6;

	logic clock;
	logic reset;
	logic [31:0] virtualAddress;
	logic affectRandomIndexCounter;
	logic randomizeEntryIndex;
	logic writeEntryEnable;
	specialRegisterT specialRegisterReadIndex;
	logic [31:0] specialRegisterExplicitWriteValue;
	logic tlbIndexWriteEnable;
	indexSourceT tlbIndexDataSource;
	logic tlbEntryHighWriteEnable;
	highSourceT tlbEntryHighDataSource;
	logic tlbEntryLowWriteEnable;
	lowSourceT tlbEntryLowDataSource;
	logic tlbBadAddressWriteEnable;
	badSourceT tlbBadAddressDataSource;
	logic tlbMiss;
	logic [31:0] physicalAddress;
	logic physicalAddressWriteAllowed;
	logic physicalAddressValid;
	logic [31:0] specialRegisterReadValue;
	int translationErrors;
	int registerErrors;
	int translationChecks;
	int registerChecks;

	// a few page numbers reused often, so hits and duplicate keys show up
	pageNumberT pagePool [poolSize];

	memoryManagementUnit UUT (.*);

	mmuChecker resultCheck (.*);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic clearControls();
		randomizeEntryIndex = 1'b0;
		writeEntryEnable = 1'b0;
		tlbIndexWriteEnable = 1'b0;
		tlbEntryHighWriteEnable = 1'b0;
		tlbEntryLowWriteEnable = 1'b0;
		tlbBadAddressWriteEnable = 1'b0;
	endtask

	// mostly pool pages, some direct-mapped and some fully random addresses
	function automatic logic [31:0] pickAddress();
		int choice = $urandom_range(0, 7);
		if (choice < 5) begin
			return {pagePool[$urandom_range(0, poolSize - 1)], 12'($urandom)};
		end else if (choice == 5) begin
			return {2'b11, 30'($urandom)};
		end
		return $urandom;
	endfunction

	function automatic logic [31:0] pickExplicitValue();
		if ($urandom_range(0, 1) == 0) begin
			return {pagePool[$urandom_range(0, poolSize - 1)], 12'($urandom)};
		end
		return $urandom;
	endfunction

	// kind 0 translates, 1 is TBWI, 2 is TBWR, 3 is TBS with loads, 4 is explicit loads
	task automatic driveOperation(input int kind);
		clearControls();
		virtualAddress = pickAddress();
		affectRandomIndexCounter = 1'($urandom_range(0, 1));
		specialRegisterReadIndex = specialRegisterT'(3'($urandom_range(0, 7)));
		specialRegisterExplicitWriteValue = pickExplicitValue();
		case (kind)
			0: begin
				// translation only, which every cycle does anyway
			end
			1: begin
				writeEntryEnable = 1'b1;
			end
			2: begin
				writeEntryEnable = 1'b1;
				randomizeEntryIndex = 1'b1;
			end
			3: begin
				tlbIndexWriteEnable = 1'b1;
				tlbIndexDataSource = indexSearch;
				tlbEntryHighWriteEnable = 1'($urandom_range(0, 1));
				tlbEntryHighDataSource = $urandom_range(0, 1) ? highVirtualAddress : highReadEntry;
				tlbEntryLowWriteEnable = 1'($urandom_range(0, 1));
				tlbEntryLowDataSource = $urandom_range(0, 1) ? lowMatchValue : lowReadEntry;
				tlbBadAddressWriteEnable = 1'($urandom_range(0, 1));
				tlbBadAddressDataSource = badVirtualAddress;
			end
			default: begin
				// any legal source, read-entry loads included since the index register is used
				tlbIndexWriteEnable = 1'($urandom_range(0, 1));
				tlbIndexDataSource = indexSourceT'($urandom_range(0, 1));
				tlbEntryHighWriteEnable = 1'($urandom_range(0, 1));
				tlbEntryHighDataSource = highSourceT'($urandom_range(0, 2));
				tlbEntryLowWriteEnable = 1'($urandom_range(0, 1));
				tlbEntryLowDataSource = lowSourceT'($urandom_range(0, 2));
				tlbBadAddressWriteEnable = 1'($urandom_range(0, 1));
				tlbBadAddressDataSource = badSourceT'($urandom_range(0, 1));
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		void'($urandom(32'haeb8));
		reset = 1'b1;
		clearControls();
		virtualAddress = '0;
		affectRandomIndexCounter = 1'b0;
		specialRegisterReadIndex = registerIndex;
		specialRegisterExplicitWriteValue = '0;
		tlbIndexDataSource = indexExplicit;
		tlbEntryHighDataSource = highExplicit;
		tlbEntryLowDataSource = lowExplicit;
		tlbBadAddressDataSource = badExplicit;
		// page 0 matches every entry right after reset
		pagePool[0] = '0;
		for (int i = 1; i < poolSize; i++) begin
			pagePool[i] = {1'b0, 19'($urandom)};
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// every read code once while all registers still hold their reset value
		for (int code = 0; code < 8; code++) begin
			@(negedge clock);
			specialRegisterReadIndex = specialRegisterT'(3'(code));
		end
		for (int n = 0; n < operationCount; n++) begin
			@(negedge clock);
			driveOperation($urandom_range(0, 4));
		end
		@(negedge clock);
		clearControls();
		repeat (2) @(negedge clock);
		$display("translation checks %0d errors %0d, register checks %0d errors %0d",
			translationChecks, translationErrors, registerChecks, registerErrors);
		if (translationErrors + registerErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// the sequence needs a little over operationCount cycles
	initial begin
		#((operationCount + marginCycles) * clockPeriod);
		$display("Timeout: the run did not finish within %0d ns",
			(operationCount + marginCycles) * clockPeriod);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
src/mmuPkg.sv
src/tlbPort.sv
src/tlbEntryStore.sv
src/tlbRegisterFile.sv
src/translationUnit.sv
src/memoryManagementUnit.sv
tb/mmuChecker.sv
tb/mmuTestbench.sv
